/* all.f */
+incdir+verilog
verilog/conv_pkg.sv
verilog/axil_pkg.sv
verilog/axil_cmd_slave.sv
verilog/tap_loader.sv
verilog/mac_lane.sv
verilog/sum_reducer.sv
verilog/conv_accel_top.sv
verification/conv_accel_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := conv_accel_tb
RTL_TOP    := conv_accel_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only when the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/conv_testdata.txt */
# Columns: op, then hex fields. test <name> | end | run <result> | ctrl <bits> <resp>
# wf/wd <resp> <count> <words> | rd <addr> <data> <resp>   (resp 0 OKAY, 2 SLVERR)
test reset_state
rd 0c 00000000 0
rd 10 00000000 0
rd 14 00000000 2
end
test full_dot
wf 0 4 1 2 3 4
wd 0 4 10000000 10000001 10000002 10000003
wf 0 4 5 6 7 8
wd 0 4 10000004 10000005 10000006 10000007
wf 0 4 9 a b c
wd 0 4 10000008 10000009 1000000a 1000000b
wf 0 4 d e f 10
wd 0 4 1000000c 1000000d 1000000e 1000000f
run 80000550
end
test partial_taps
ctrl 3 0
wf 0 6 2 3 5 7 b d
wd 0 10 ffffffff 2 3 4 5 6 7 8 9 a
run 000000b4
end
test refused_loads
# Ready is still high from the last run
wf 2 1 5
wd 2 1 5
rd 10 000000b4 0
ctrl 3 0
rd 0c 00000000 0
wf 0 8 1 1 1 1 1 1 1 1
wf 0 8 1 1 1 1 1 1 1 1
wf 2 1 deadbeef
rd 10 000000b4 0
end
test filter_reload
wd 0 4 3 5 7 9
run 00000018
ctrl 1 0
rd 0c 00000000 0
wf 0 4 80000000 20 30 40
run 80000430
end

/* verification/conv_accel_tb.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_accel_tb
    import axil_pkg::*;
    import conv_pkg::*;
();

    logic       clk_i;
    logic       rst_i;
    axil_addr_t s_awaddr_i;
    logic       s_awvalid_i;
    logic       s_awready_o;
    word_t      s_wdata_i;
    logic       s_wvalid_i;
    logic       s_wready_o;
    axil_resp_t s_bresp_o;
    logic       s_bvalid_o;
    logic       s_bready_i;
    axil_addr_t s_araddr_i;
    logic       s_arvalid_i;
    logic       s_arready_o;
    word_t      s_rdata_o;
    axil_resp_t s_rresp_o;
    logic       s_rvalid_o;
    logic       s_rready_i;

    // One entry per bus operation, taken from the data file
    string      op_q[$];
    string      name_q[$];
    word_t      arg_a_q[$];
    word_t      arg_b_q[$];
    word_t      arg_c_q[$];

    word_t      ref_filter[`CONV_TAPS];
    word_t      ref_data[`CONV_TAPS];
    int         ref_fcount = 0;
    int         ref_dcount = 0;
    logic       ref_ready = 1'b0;

    int         err_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycle_limit = 0;

    logic       b_hold = 1'b0;
    logic       r_hold = 1'b0;
    axil_resp_t b_resp_q;
    axil_resp_t r_resp_q;
    word_t      r_data_q;

    conv_accel_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_value(input string sig, input word_t exp_val, input word_t act_val);
        assert (act_val === exp_val) else begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, sig, exp_val, act_val);
            err_count++;
        end
    endtask

    task automatic bus_write(input axil_addr_t addr, input word_t data, output axil_resp_t resp);
        int unsigned delay;
        @(negedge clk_i);
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        @(posedge clk_i);
        while (!s_awready_o) @(posedge clk_i);
        check_value("s_wready_o", word_t'(1'b1), word_t'(s_wready_o));
        @(negedge clk_i);
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        delay = $urandom % 4;  // Host back-pressure on B
        repeat (delay) @(negedge clk_i);
        s_bready_i = 1'b1;
        @(posedge clk_i);
        while (!s_bvalid_o) @(posedge clk_i);
        resp = s_bresp_o;
        @(negedge clk_i);
        s_bready_i = 1'b0;
    endtask

    task automatic bus_read(input axil_addr_t addr, output word_t data, output axil_resp_t resp);
        int unsigned delay;
        @(negedge clk_i);
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        @(posedge clk_i);
        while (!s_arready_o) @(posedge clk_i);
        @(negedge clk_i);
        s_arvalid_i = 1'b0;
        delay = $urandom % 4;
        repeat (delay) @(negedge clk_i);
        s_rready_i = 1'b1;
        @(posedge clk_i);
        while (!s_rvalid_o) @(posedge clk_i);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(negedge clk_i);
        s_rready_i = 1'b0;
    endtask

    // Wrapped sum of products over indices where both taps are loaded
    function automatic word_t expected_dot();
        word_t sum;
        int    n;
        sum = '0;
        n = (ref_fcount < ref_dcount) ? ref_fcount : ref_dcount;
        for (int i = 0; i < n; i++) begin
            sum = sum + ref_filter[i] * ref_data[i];
        end
        return sum;
    endfunction

    task automatic load_tap(input logic is_filter, input word_t word, input word_t exp_resp);
        axil_resp_t resp;
        logic       accept;
        int         count;
        count  = is_filter ? ref_fcount : ref_dcount;
        accept = (count < `CONV_TAPS) && !ref_ready;
        check_value("bresp in test data", word_t'(accept ? RESP_OKAY : RESP_SLVERR), exp_resp);
        bus_write(is_filter ? `CONV_ADDR_FILTER : `CONV_ADDR_DATA, word, resp);
        check_value("s_bresp_o", exp_resp, word_t'(resp));
        if (accept && is_filter) begin
            ref_filter[ref_fcount] = word;
            ref_fcount++;
        end else if (accept) begin
            ref_data[ref_dcount] = word;
            ref_dcount++;
        end
    endtask

    task automatic write_ctrl(input word_t bits, input word_t exp_resp);
        axil_resp_t resp;
        bus_write(`CONV_ADDR_CTRL, bits, resp);
        check_value("s_bresp_o", exp_resp, word_t'(resp));
        if (bits[CLR_FILTER]) begin
            ref_fcount = 0;
            ref_ready  = 1'b0;
        end
        if (bits[CLR_DATA]) begin
            ref_dcount = 0;
            ref_ready  = 1'b0;
        end
    endtask

    task automatic read_and_check(input word_t addr, input word_t exp_data, input word_t exp_resp);
        axil_resp_t resp;
        word_t      rdata;
        bus_read(axil_addr_t'(addr), rdata, resp);
        check_value("s_rdata_o", exp_data, rdata);
        check_value("s_rresp_o", exp_resp, word_t'(resp));
    endtask

    task automatic run_and_check(input word_t exp_result);
        axil_resp_t resp;
        word_t      rdata;
        status_t    status;
        check_value("result in test data", expected_dot(), exp_result);
        bus_write(`CONV_ADDR_CTRL, word_t'(1) << RUN, resp);
        check_value("s_bresp_o", word_t'(RESP_OKAY), word_t'(resp));
        status = '0;
        while (!status.ready) begin  // Latency depends on how many pairs are left
            bus_read(`CONV_ADDR_STATUS, rdata, resp);
            check_value("s_rresp_o", word_t'(RESP_OKAY), word_t'(resp));
            status = rdata;
        end
        check_value("STATUS.pending", '0, word_t'(status.pending));
        bus_read(`CONV_ADDR_RESULT, rdata, resp);
        check_value("s_rresp_o", word_t'(RESP_OKAY), word_t'(resp));
        check_value("RESULT", exp_result, rdata);
        ref_ready = 1'b1;
    endtask

    function automatic void push_op(input string op, input string name,
                                    input word_t a, input word_t b, input word_t c);
        op_q.push_back(op);
        name_q.push_back(name);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
        arg_c_q.push_back(c);
    endfunction

    task automatic read_test_file(output int bus_ops);
        int    fd;
        int    rc;
        int    count;
        string tok;
        string name;
        string rest;
        word_t a;
        word_t b;
        word_t c;
        bus_ops = 0;
        fd = $fopen("verification/conv_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/conv_testdata.txt");
            err_count++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                rc = $fgets(rest, fd);
            end else if (tok == "test") begin
                rc = $fscanf(fd, "%s", name);
                push_op(tok, name, '0, '0, '0);
            end else if (tok == "wf" || tok == "wd") begin
                rc = $fscanf(fd, "%h %d", b, count);
                repeat (count) begin
                    rc = $fscanf(fd, "%h", a);
                    push_op(tok, "", a, b, '0);
                    bus_ops++;
                end
            end else if (tok == "ctrl") begin
                rc = $fscanf(fd, "%h %h", a, b);
                push_op(tok, "", a, b, '0);
                bus_ops++;
            end else if (tok == "rd") begin
                rc = $fscanf(fd, "%h %h %h", a, b, c);
                push_op(tok, "", a, b, c);
                bus_ops++;
            end else if (tok == "run") begin
                rc = $fscanf(fd, "%h", a);
                push_op(tok, "", a, '0, '0);
                bus_ops += 3;  // CTRL write, at least one poll, RESULT read
            end else if (tok == "end") begin
                push_op(tok, "", '0, '0, '0);
            end else begin
                $display("unknown operation %s in the test data file", tok);
                err_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_tests();
        string name;
        int    err_start;
        name      = "";
        err_start = err_count;
        foreach (op_q[i]) begin
            if (op_q[i] == "test") begin
                name      = name_q[i];
                err_start = err_count;
            end else if (op_q[i] == "wf" || op_q[i] == "wd") begin
                load_tap(op_q[i] == "wf", arg_a_q[i], arg_b_q[i]);
            end else if (op_q[i] == "ctrl") begin
                write_ctrl(arg_a_q[i], arg_b_q[i]);
            end else if (op_q[i] == "rd") begin
                read_and_check(arg_a_q[i], arg_b_q[i], arg_c_q[i]);
            end else if (op_q[i] == "run") begin
                run_and_check(arg_a_q[i]);
            end else if (err_count == err_start) begin
                tests_passed++;
                $display("test %s: ok", name);
            end else begin
                tests_failed++;
                $display("test %s: %0d errors", name, err_count - err_start);
            end
        end
    endtask

    // Responses must hold while valid waits for ready
    always @(posedge clk_i) begin
        if (b_hold) begin
            assert (s_bvalid_o) else begin
                $display("s_bvalid_o fell at %0t before bready took the response", $time);
                err_count++;
            end
            check_value("s_bresp_o while held", word_t'(b_resp_q), word_t'(s_bresp_o));
        end
        if (r_hold) begin
            assert (s_rvalid_o) else begin
                $display("s_rvalid_o fell at %0t before rready took the data", $time);
                err_count++;
            end
            check_value("s_rresp_o while held", word_t'(r_resp_q), word_t'(s_rresp_o));
            check_value("s_rdata_o while held", r_data_q, s_rdata_o);
        end
        b_hold   <= !rst_i && s_bvalid_o && !s_bready_i;
        b_resp_q <= s_bresp_o;
        r_hold   <= !rst_i && s_rvalid_o && !s_rready_i;
        r_resp_q <= s_rresp_o;
        r_data_q <= s_rdata_o;
    end

    initial begin
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clk_i);
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int bus_ops;
        void'($urandom(32'h211c_ded9));
        rst_i       = 1'b1;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        read_test_file(bus_ops);
        cycle_limit = bus_ops * 40 + 1000;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        run_tests();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/conv_accel_top.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_accel_top
    import axil_pkg::*;
    import conv_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  axil_addr_t s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  word_t      s_wdata_i,
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output axil_resp_t s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  axil_addr_t s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output word_t      s_rdata_o,
    output axil_resp_t s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i
);

    logic                    load_filter, load_data;
    logic                    clear_filter, clear_data, clear_any;
    logic                    run;
    logic                    filter_full, data_full;
    logic                    ready, pending;
    word_t                   word, lane_word, result;
    lane_mask_t              filter_we, data_we, lane_idle;
    slot_t                   slot;
    word_t [`CONV_LANES-1:0] partials;

    assign clear_any = clear_filter || clear_data;  // Either clear restarts every lane

    axil_cmd_slave u_slave (
        .clk_i(clk_i), .rst_i(rst_i),
        .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
        .s_wdata_i(s_wdata_i), .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o),
        .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
        .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
        .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
        .s_rready_i(s_rready_i),
        .load_filter_o(load_filter), .load_data_o(load_data), .word_o(word),
        .clear_filter_o(clear_filter), .clear_data_o(clear_data), .run_o(run),
        .filter_full_i(filter_full), .data_full_i(data_full),
        .ready_i(ready), .pending_i(pending), .result_i(result)
    );

    tap_loader u_loader (
        .clk_i(clk_i), .rst_i(rst_i),
        .load_filter_i(load_filter), .load_data_i(load_data),
        .clear_filter_i(clear_filter), .clear_data_i(clear_data), .word_i(word),
        .filter_we_o(filter_we), .data_we_o(data_we), .slot_o(slot),
        .lane_word_o(lane_word), .filter_full_o(filter_full), .data_full_o(data_full)
    );

    for (genvar i = 0; i < `CONV_LANES; i++) begin : g_lane
        mac_lane u_lane (
            .clk_i(clk_i), .rst_i(rst_i),
            .filter_we_i(filter_we[i]), .data_we_i(data_we[i]),
            .slot_i(slot), .word_i(lane_word),
            .clear_filter_i(clear_filter), .clear_data_i(clear_data),
            .partial_o(partials[i]), .idle_o(lane_idle[i])
        );
    end

    sum_reducer u_reducer (
        .clk_i(clk_i), .rst_i(rst_i), .run_i(run), .clear_i(clear_any),
        .partials_i(partials), .idle_i(lane_idle),
        .result_o(result), .ready_o(ready), .pending_o(pending)
    );

endmodule

/* verilog/sum_reducer.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module sum_reducer
    import conv_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     run_i,
    input  logic                     clear_i,
    input  word_t [`CONV_LANES-1:0] partials_i,
    input  lane_mask_t               idle_i,
    output word_t                    result_o,
    output logic                     ready_o,
    output logic                     pending_o
);

    word_t lane_sum;
    logic  drain;

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `CONV_LANES; i++) begin
            lane_sum = lane_sum + partials_i[i];
        end
    end

    // Run completes once no lane has a pair left to consume
    assign drain = pending_o && (&idle_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_o <= 1'b0;
            ready_o   <= 1'b0;
        end else if (clear_i) begin
            pending_o <= run_i;  // Clear and run in one CTRL write
            ready_o   <= 1'b0;
        end else if (drain) begin
            pending_o <= 1'b0;
            ready_o   <= 1'b1;
        end else if (run_i && !ready_o) begin
            pending_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
        end else if (drain) begin
            result_o <= lane_sum;
        end
    end

endmodule

/* verilog/mac_lane.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module mac_lane
    import conv_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  filter_we_i,
    input  logic  data_we_i,
    input  slot_t slot_i,
    input  word_t word_i,
    input  logic  clear_filter_i,
    input  logic  clear_data_i,
    output word_t partial_o,
    output logic  idle_o
);

    localparam int CUR_BITS = $clog2(`CONV_SLOTS) + 1;  // Extra bit marks all slots done

    word_t                  filter_q [`CONV_SLOTS];
    word_t                  data_q [`CONV_SLOTS];
    logic [`CONV_SLOTS-1:0] filter_vld_q;
    logic [`CONV_SLOTS-1:0] data_vld_q;
    logic [CUR_BITS-1:0]    cursor_q;
    word_t                  acc_q;
    slot_t                  cur_slot;
    logic                   pair_rdy;

    assign cur_slot  = cursor_q[CUR_BITS-2:0];
    assign pair_rdy  = (cursor_q != CUR_BITS'(`CONV_SLOTS))
                       && filter_vld_q[cur_slot] && data_vld_q[cur_slot];
    assign idle_o    = !pair_rdy;
    assign partial_o = acc_q;

    always_ff @(posedge clk_i) begin
        if (clear_filter_i) begin
            for (int i = 0; i < `CONV_SLOTS; i++) begin
                filter_q[i] <= '0;
            end
        end else if (filter_we_i) begin
            filter_q[slot_i] <= word_i;
        end
        if (clear_data_i) begin
            for (int i = 0; i < `CONV_SLOTS; i++) begin
                data_q[i] <= '0;
            end
        end else if (data_we_i) begin
            data_q[slot_i] <= word_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_filter_i) begin
            filter_vld_q <= '0;
        end else if (filter_we_i) begin
            filter_vld_q[slot_i] <= 1'b1;
        end
        if (rst_i || clear_data_i) begin
            data_vld_q <= '0;
        end else if (data_we_i) begin
            data_vld_q[slot_i] <= 1'b1;
        end
    end

    // One pair per cycle, low 32 bits kept
    always_ff @(posedge clk_i) begin
        if (rst_i || clear_filter_i || clear_data_i) begin
            acc_q    <= '0;
            cursor_q <= '0;
        end else if (pair_rdy) begin
            acc_q    <= acc_q + filter_q[cur_slot] * data_q[cur_slot];
            cursor_q <= cursor_q + 1'b1;
        end
    end

    // Loader counts must never revisit a filled slot
    assert property (@(posedge clk_i) disable iff (rst_i)
        !((filter_we_i && filter_vld_q[slot_i]) || (data_we_i && data_vld_q[slot_i])))
        else $error("write to filled slot %0d", slot_i);

endmodule

/* verilog/tap_loader.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module tap_loader
    import conv_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       load_filter_i,
    input  logic       load_data_i,
    input  logic       clear_filter_i,
    input  logic       clear_data_i,
    input  word_t      word_i,
    output lane_mask_t filter_we_o,
    output lane_mask_t data_we_o,
    output slot_t      slot_o,
    output word_t      lane_word_o,
    output logic       filter_full_o,
    output logic       data_full_o
);

    localparam int LANE_BITS = $clog2(`CONV_LANES);
    localparam int SLOT_BITS = $clog2(`CONV_SLOTS);

    count_t     filter_count_q;
    count_t     data_count_q;
    count_t     load_count;
    lane_mask_t lane_sel;

    // Only one kind of load can arrive per cycle
    assign load_count = load_filter_i ? filter_count_q : data_count_q;
    assign lane_sel   = lane_mask_t'(1'b1) << load_count[LANE_BITS-1:0];  // Index mod 4

    assign filter_full_o = (filter_count_q == count_t'(`CONV_TAPS));
    assign data_full_o   = (data_count_q == count_t'(`CONV_TAPS));

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_filter_i) begin
            filter_count_q <= '0;
        end else if (load_filter_i) begin
            filter_count_q <= filter_count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_data_i) begin
            data_count_q <= '0;
        end else if (load_data_i) begin
            data_count_q <= data_count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            filter_we_o <= '0;
            data_we_o   <= '0;
        end else begin
            filter_we_o <= load_filter_i ? lane_sel : '0;
            data_we_o   <= load_data_i ? lane_sel : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_filter_i || load_data_i) begin
            slot_o      <= load_count[LANE_BITS +: SLOT_BITS];  // Index div 4
            lane_word_o <= word_i;
        end
    end

    // The slave must refuse loads once a kind is full
    assert property (@(posedge clk_i) disable iff (rst_i)
        (filter_count_q <= count_t'(`CONV_TAPS)) && (data_count_q <= count_t'(`CONV_TAPS)))
        else $error("tap count beyond %0d", `CONV_TAPS);

endmodule

/* verilog/axil_cmd_slave.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module axil_cmd_slave
    import axil_pkg::*;
    import conv_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    input  axil_addr_t s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  word_t      s_wdata_i,
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output axil_resp_t s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  axil_addr_t s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output word_t      s_rdata_o,
    output axil_resp_t s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i,

    output logic       load_filter_o,
    output logic       load_data_o,
    output word_t      word_o,
    output logic       clear_filter_o,
    output logic       clear_data_o,
    output logic       run_o,

    input  logic       filter_full_i,
    input  logic       data_full_i,
    input  logic       ready_i,
    input  logic       pending_i,
    input  word_t      result_i
);

    logic       wr_hs;
    logic       wr_ok;
    logic       ctrl_wr;
    logic       ar_hs;
    logic       arready_q;
    logic       rvalid_next;
    word_t      rd_data;
    axil_resp_t rd_resp;
    status_t    status;

    // Address and data are taken in the same cycle, never while B is pending
    assign wr_hs       = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
    assign s_awready_o = wr_hs;
    assign s_wready_o  = wr_hs;

    always_comb begin
        case (s_awaddr_i)
            `CONV_ADDR_FILTER: wr_ok = !filter_full_i && !ready_i;
            `CONV_ADDR_DATA:   wr_ok = !data_full_i && !ready_i;
            `CONV_ADDR_CTRL:   wr_ok = 1'b1;
            default:           wr_ok = 1'b0;   // Read-only or unmapped
        endcase
    end

    assign ctrl_wr        = wr_hs && (s_awaddr_i == `CONV_ADDR_CTRL);
    assign load_filter_o  = wr_hs && wr_ok && (s_awaddr_i == `CONV_ADDR_FILTER);
    assign load_data_o    = wr_hs && wr_ok && (s_awaddr_i == `CONV_ADDR_DATA);
    assign word_o         = s_wdata_i;
    assign clear_filter_o = ctrl_wr && s_wdata_i[CLR_FILTER];
    assign clear_data_o   = ctrl_wr && s_wdata_i[CLR_DATA];
    assign run_o          = ctrl_wr && s_wdata_i[RUN];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s_bvalid_o <= 1'b0;
        end else if (wr_hs) begin
            s_bvalid_o <= 1'b1;
        end else if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            s_bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign status = '{rsvd: '0, pending: pending_i, ready: ready_i};

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (s_araddr_i)
            `CONV_ADDR_STATUS: rd_data = status;
            `CONV_ADDR_RESULT: rd_data = result_i;
            default:           rd_resp = RESP_SLVERR;
        endcase
    end

    assign ar_hs       = s_arvalid_i && arready_q;
    assign rvalid_next = ar_hs || (s_rvalid_o && !s_rready_i);
    assign s_arready_o = arready_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s_rvalid_o <= 1'b0;
            arready_q  <= 1'b0;
        end else begin
            s_rvalid_o <= rvalid_next;
            arready_q  <= !rvalid_next;  // Open again once R has drained
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            s_rdata_o <= rd_data;
            s_rresp_o <= rd_resp;
        end
    end

    // A write response is held until the host takes it
    assert property (@(posedge clk_i) disable iff (rst_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
        else $error("bvalid dropped without bready");

endmodule

/* verilog/axil_pkg.sv */
`include "conv_consts.svh"

package axil_pkg;

    typedef logic [`CONV_ADDR_BITS-1:0] axil_addr_t;

    // BRESP / RRESP encodings in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

endpackage

/* verilog/conv_pkg.sv */
`include "conv_consts.svh"

package conv_pkg;

    typedef logic [`CONV_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CONV_SLOTS)-1:0] slot_t;
    typedef logic [`CONV_LANES-1:0] lane_mask_t;
    typedef logic [$clog2(`CONV_TAPS+1)-1:0] count_t;  // Holds 0 to 16

    // Bit positions inside the CTRL word
    typedef enum logic [1:0] {
        CLR_FILTER = 2'd0,
        CLR_DATA   = 2'd1,
        RUN        = 2'd2
    } ctrl_bit_e;

    // STATUS word, ready in bit 0
    typedef struct packed {
        logic [`CONV_WIDTH-3:0] rsvd;
        logic                   pending;
        logic                   ready;
    } status_t;

endpackage

/* verilog/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Tap storage geometry
`define CONV_TAPS  16
`define CONV_LANES 4
`define CONV_SLOTS 4

`define CONV_WIDTH 32

// Register map, one word per register
`define CONV_ADDR_BITS   8
`define CONV_ADDR_FILTER 8'h00
`define CONV_ADDR_DATA   8'h04
`define CONV_ADDR_CTRL   8'h08
`define CONV_ADDR_STATUS 8'h0C
`define CONV_ADDR_RESULT 8'h10

`endif
